/* dinoGame.sv */
`timescale 1ns/1ps

module dinoGame #(
    parameter int FRAME_CYCLES = 833333,
    parameter int STEP_FRAMES  = 3
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     jump,
    input  logic                     pause,
    output dinoGamePkg::gamePhaseT   gamePhase,
    output dinoGamePkg::scoreDigitsT score,
    output logic                     pixelValid,
    output dinoGeomPkg::coordT       pixelX,
    output dinoGeomPkg::coordT       pixelY,
    output dinoGamePkg::pixelColorT  pixelColor
);
    import dinoGeomPkg::*;

    logic  frameTick;
    logic  stepTick;
    logic  collide;
    coordT obs1X;
    coordT obs2X;

    gameControl gameControl_i (
        .clk       (clk),
        .resetn    (resetn),
        .jump      (jump),
        .pause     (pause),
        .collide   (collide),
        .gamePhase (gamePhase)
    );

    frameTimer #(
        .FRAME_CYCLES (FRAME_CYCLES),
        .STEP_FRAMES  (STEP_FRAMES)
    ) frameTimer_i (
        .clk       (clk),
        .resetn    (resetn),
        .gamePhase (gamePhase),
        .frameTick (frameTick),
        .stepTick  (stepTick)
    );

    obstacleWorld obstacleWorld_i (
        .clk       (clk),
        .resetn    (resetn),
        .gamePhase (gamePhase),
        .stepTick  (stepTick),
        .obs1X     (obs1X),
        .obs2X     (obs2X),
        .collide   (collide)
    );

    scoreCounter scoreCounter_i (
        .clk       (clk),
        .resetn    (resetn),
        .gamePhase (gamePhase),
        .stepTick  (stepTick),
        .score     (score)
    );

    pixelScanner pixelScanner_i (
        .clk        (clk),
        .resetn     (resetn),
        .frameTick  (frameTick),
        .obs1X      (obs1X),
        .obs2X      (obs2X),
        .pixelValid (pixelValid),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .pixelColor (pixelColor)
    );

endmodule

/* dinoGamePkg.sv */
package dinoGamePkg;

    // Controller states. Each wait state holds until the button is released.
    typedef enum logic [3:0] {
        MENU         = 4'b0000,
        MENU_WAIT    = 4'b0001,
        RUNNING      = 4'b0011,
        RUNNING_WAIT = 4'b0111,
        PAUSE        = 4'b1111,
        PAUSE_WAIT   = 4'b1011,
        OVER         = 4'b0010,
        OVER_WAIT1   = 4'b0110,
        OVER_WAIT2   = 4'b0100
    } gameStateT;

    // Phase seen by the datapath.
    typedef enum logic [1:0] {
        PH_MENU    = 2'd0,
        PH_RUNNING = 2'd1,
        PH_PAUSED  = 2'd2,
        PH_OVER    = 2'd3
    } gamePhaseT;

    typedef enum logic [2:0] {
        COL_DINO   = 3'd2,
        COL_BG     = 3'd3,
        COL_OBS1   = 3'd4,
        COL_OBS2   = 3'd5,
        COL_GROUND = 3'd6
    } pixelColorT;

    localparam int SCORE_DIGITS = 6;

    // BCD digits, index 0 is the ones digit.
    typedef logic [SCORE_DIGITS-1:0][3:0] scoreDigitsT;

endpackage

/* dinoGameTb.sv */
`timescale 1ns/1ps

module dinoGameTb;
    import dinoGeomPkg::*;
    import dinoGamePkg::*;

    localparam int FRAME_CYCLES = 20000;
    localparam int STEP_FRAMES  = 1;
    localparam int HIT_COLUMN   = DINO_RIGHT - 1;           // First column that overlaps.
    localparam int HIT_STEPS    = OBS1_START - HIT_COLUMN;

    logic        clk;
    logic        resetn;
    logic        jump;
    logic        pause;
    gamePhaseT   gamePhase;
    scoreDigitsT score;
    logic        pixelValid;
    coordT       pixelX;
    coordT       pixelY;
    pixelColorT  pixelColor;

    int          errorCount;
    int          timeoutCount;
    int          seedVal;
    scoreDigitsT prevScore;

    dinoGame #(
        .FRAME_CYCLES (FRAME_CYCLES),
        .STEP_FRAMES  (STEP_FRAMES)
    ) dinoGame_i (
        .clk        (clk),
        .resetn     (resetn),
        .jump       (jump),
        .pause      (pause),
        .gamePhase  (gamePhase),
        .score      (score),
        .pixelValid (pixelValid),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .pixelColor (pixelColor)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Colour priority, ground first and background last.
    function automatic pixelColorT expectedColor(int x, int y, int o1, int o2);
        if (y >= GROUND_TOP)
            return COL_GROUND;
        if (x >= DINO_LEFT && x < DINO_RIGHT && y >= DINO_TOP)
            return COL_DINO;
        if (x >= o1 && x < o1 + OBS_W && y >= GROUND_TOP - OBS1_H)
            return COL_OBS1;
        if (x >= o2 && x < o2 + OBS_W && y >= GROUND_TOP - OBS2_H)
            return COL_OBS2;
        return COL_BG;
    endfunction

    function automatic int toInt(scoreDigitsT s);
        int value;
        int scale;
        value = 0;
        scale = 1;
        for (int i = 0; i < SCORE_DIGITS; i++) begin
            value = value + int'(s[i]) * scale;
            scale = scale * 10;
        end
        return value;
    endfunction

    function automatic scoreDigitsT toScore(int v);
        scoreDigitsT r;
        for (int i = 0; i < SCORE_DIGITS; i++) begin
            r[i] = 4'(v % 10);
            v    = v / 10;
        end
        return r;
    endfunction

    // Decimal increment, wrapping past all nines.
    function automatic scoreDigitsT bcdNext(scoreDigitsT s);
        return toScore((toInt(s) + 1) % (10 ** SCORE_DIGITS));
    endfunction

    // Score watcher. A change is one decimal step or a clear in the menu.
    always @(negedge clk) begin
        if (resetn && score != prevScore) begin
            if (!(score == '0 && gamePhase == PH_MENU) && score != bcdNext(prevScore)) begin
                errorCount++;
                $display("MISMATCH %0t: score %h after %h, expected %h",
                         $time, score, prevScore, bcdNext(prevScore));
            end
        end
        for (int d = 0; d < SCORE_DIGITS; d++) begin
            if (resetn && score[d] > 4'd9) begin
                errorCount++;
                $display("MISMATCH %0t: score digit %0d holds %0d", $time, d, score[d]);
            end
        end
        prevScore = score;
    end

    task automatic waitValid(input logic level, input int limit, input string what);
        int cnt;
        cnt = 0;
        while (pixelValid !== level && cnt < limit) begin
            @(negedge clk);
            cnt++;
        end
        if (pixelValid !== level) begin
            timeoutCount++;
            $display("ERROR %0t: timed out waiting for %s", $time, what);
        end
    endtask

    task automatic waitPhase(input gamePhaseT ph, input int limit, input string what);
        int cnt;
        cnt = 0;
        while (gamePhase != ph && cnt < limit) begin
            @(negedge clk);
            cnt++;
        end
        if (gamePhase != ph) begin
            timeoutCount++;
            $display("ERROR %0t: timed out waiting for %s, phase is %s",
                     $time, what, gamePhase.name());
        end
    endtask

    task automatic waitScore(input scoreDigitsT v, input int limit, input string what);
        int cnt;
        cnt = 0;
        while (score != v && cnt < limit) begin
            @(negedge clk);
            cnt++;
        end
        if (score != v) begin
            timeoutCount++;
            $display("ERROR %0t: timed out waiting for %s, score is %h", $time, what, score);
        end
    endtask

    // Press for a random number of cycles. The phase must not move while held.
    task automatic pressButton(input bit usePause, input gamePhaseT holdPhase);
        int holdCycles;
        holdCycles = int'($urandom % 8) + 1;
        @(posedge clk);
        #2;
        if (usePause)
            pause = 1'b1;
        else
            jump = 1'b1;
        for (int i = 0; i < holdCycles; i++) begin
            @(negedge clk);
            if (gamePhase != holdPhase) begin
                errorCount++;
                $display("MISMATCH %0t: phase %s while button held, expected %s",
                         $time, gamePhase.name(), holdPhase.name());
            end
        end
        @(posedge clk);
        #2;
        jump  = 1'b0;
        pause = 1'b0;
    endtask

    // Captures the next whole frame and checks order and colour.
    task automatic checkFrame(input int o1, input int o2, input string name);
        int         bad;
        int         ex;
        int         ey;
        pixelColorT ec;
        waitValid(1'b0, 2 * FRAME_CYCLES, {name, " gap"});
        if (timeoutCount != 0)
            return;
        waitValid(1'b1, 2 * FRAME_CYCLES, {name, " start"});
        if (timeoutCount != 0)
            return;
        bad = 0;
        for (int n = 0; n < PIXELS_PER_FRAME; n++) begin
            ex = n % SCREEN_W;     // x runs fastest.
            ey = n / SCREEN_W;
            ec = expectedColor(ex, ey, o1, o2);
            if (!pixelValid || int'(pixelX) != ex || int'(pixelY) != ey || pixelColor != ec) begin
                bad++;
                if (bad <= 8)
                    $display("MISMATCH %0t: %s pixel %0d valid %0b (%0d,%0d) colour %0d, %s",
                             $time, name, n, pixelValid, pixelX, pixelY, pixelColor,
                             $sformatf("expected (%0d,%0d) colour %0d", ex, ey, ec));
            end
            @(negedge clk);
        end
        if (pixelValid) begin
            bad++;
            $display("MISMATCH %0t: %s has more than %0d pixels", $time, name, PIXELS_PER_FRAME);
        end
        errorCount += bad;
    endtask

    task automatic runSequence();
        int          cycles;
        scoreDigitsT held;
        if (gamePhase != PH_MENU || score != '0 || pixelValid) begin
            errorCount++;
            $display("MISMATCH %0t: after reset phase %s score %h valid %0b",
                     $time, gamePhase.name(), score, pixelValid);
        end
        cycles = 0;
        while (!pixelValid && cycles < 2 * FRAME_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!pixelValid) begin
            timeoutCount++;
            $display("ERROR %0t: timed out waiting for the first frame", $time);
            return;
        end
        if (cycles < FRAME_CYCLES) begin
            errorCount++;
            $display("MISMATCH %0t: first pixel after %0d cycles", $time, cycles);
        end
        checkFrame(OBS1_START, OBS2_START, "menu frame");
        if (timeoutCount != 0)
            return;

        // Release is seen on the second negedge.
        pressButton(1'b0, PH_MENU);
        waitPhase(PH_RUNNING, 2, "running after jump");
        if (timeoutCount != 0)
            return;
        waitScore(toScore(3), 5 * FRAME_CYCLES, "score of 3");
        if (timeoutCount != 0)
            return;

        pressButton(1'b1, PH_RUNNING);
        waitPhase(PH_PAUSED, 2, "paused after pause");
        if (timeoutCount != 0)
            return;
        held = score;
        repeat (3) begin
            waitValid(1'b0, 2 * FRAME_CYCLES, "frame gap while paused");
            waitValid(1'b1, 2 * FRAME_CYCLES, "frame start while paused");
        end
        if (timeoutCount != 0)
            return;
        if (score != held) begin
            errorCount++;
            $display("MISMATCH %0t: score %h while paused, expected %h", $time, score, held);
        end
        pressButton(1'b0, PH_PAUSED);
        waitPhase(PH_RUNNING, 2, "running after resume");
        if (timeoutCount != 0)
            return;

        waitPhase(PH_OVER, (HIT_STEPS + 4) * FRAME_CYCLES, "game over");
        if (timeoutCount != 0)
            return;
        if (score != toScore(HIT_STEPS)) begin
            errorCount++;
            $display("MISMATCH %0t: final score %h, expected %0d", $time, score, HIT_STEPS);
        end
        checkFrame(HIT_COLUMN, OBS2_START - HIT_STEPS, "game over frame");
        if (timeoutCount != 0)
            return;

        pressButton(bit'($urandom % 2), PH_OVER);
        waitPhase(PH_MENU, 3, "menu after game over");   // Extra wait state here.
        if (timeoutCount != 0)
            return;
        waitScore('0, 2, "score clear in menu");
        if (timeoutCount != 0)
            return;
        checkFrame(OBS1_START, OBS2_START, "menu frame after restart");
    endtask

    initial begin
        seedVal      = $urandom(43);
        errorCount   = 0;
        timeoutCount = 0;
        prevScore    = '0;
        resetn       = 1'b0;
        jump         = 1'b0;
        pause        = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        resetn = 1'b1;
        runSequence();
        $display("Errors: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* dinoGeomPkg.sv */
package dinoGeomPkg;

    // Screen coordinate, wide enough for both axes.
    typedef logic [7:0] coordT;

    // Visible raster.
    localparam int SCREEN_W         = 160;
    localparam int SCREEN_H         = 120;
    localparam int PIXELS_PER_FRAME = SCREEN_W * SCREEN_H;

    localparam int GROUND_TOP = 105;    // First ground row.

    // Dinosaur box, right edge exclusive.
    localparam int DINO_LEFT  = 15;
    localparam int DINO_RIGHT = 25;
    localparam int DINO_H     = 12;
    localparam int DINO_TOP   = GROUND_TOP - DINO_H;

    // Obstacles share one width.
    localparam int OBS_W  = 12;
    localparam int OBS1_H = 7;
    localparam int OBS2_H = 14;

    // Start columns, the second one is off screen.
    localparam int OBS1_START = 120;
    localparam int OBS2_START = 254;

endpackage

/* flist.f */
dinoGeomPkg.sv
dinoGamePkg.sv
gameControl.sv
frameTimer.sv
obstacleWorld.sv
scoreCounter.sv
pixelScanner.sv
dinoGame.sv
dinoGameTb.sv

/* frameTimer.sv */
`timescale 1ns/1ps

module frameTimer #(
    parameter int FRAME_CYCLES = 833333,
    parameter int STEP_FRAMES  = 3
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  dinoGamePkg::gamePhaseT gamePhase,
    output logic                   frameTick,
    output logic                   stepTick
);
    import dinoGamePkg::*;

    localparam int CYC_W = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;
    localparam int FR_W  = (STEP_FRAMES > 1) ? $clog2(STEP_FRAMES) : 1;

    logic [CYC_W-1:0] cycleCnt;
    logic [FR_W-1:0]  frameCnt;
    logic             running;
    logic             cycleWrap;

    assign running   = (gamePhase == PH_RUNNING);
    assign cycleWrap = (cycleCnt == CYC_W'(FRAME_CYCLES - 1));

    // Free running divider.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cycleCnt  <= '0;
            frameTick <= 1'b0;
        end else begin
            cycleCnt  <= cycleWrap ? '0 : cycleCnt + 1'b1;
            frameTick <= cycleWrap;     // One cycle pulse.
        end
    end

    // Last frame of a step, only counted while running.
    assign stepTick = frameTick && running && (frameCnt == FR_W'(STEP_FRAMES - 1));

    always_ff @(posedge clk) begin
        if (!resetn)
            frameCnt <= '0;
        else if (frameTick && running)
            frameCnt <= stepTick ? '0 : frameCnt + 1'b1;
    end

    // Count never runs past the last frame of a step.
    frameCntRange: assert property (
        @(posedge clk) disable iff (!resetn)
        int'(frameCnt) < STEP_FRAMES
    ) else $error("frameTimer: frame count %0d past step length", frameCnt);

endmodule

/* gameControl.sv */
`timescale 1ns/1ps

module gameControl (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   jump,
    input  logic                   pause,
    input  logic                   collide,
    output dinoGamePkg::gamePhaseT gamePhase
);
    import dinoGamePkg::*;

    gameStateT state;
    gameStateT nextState;
    logic      startBtn;

    assign startBtn = jump || pause;    // Either button starts or resumes.

    // Stable states arm on press, wait states fire on release.
    always_comb begin
        case (state)
            MENU:         nextState = startBtn ? MENU_WAIT : MENU;
            MENU_WAIT:    nextState = startBtn ? MENU_WAIT : RUNNING;
            RUNNING: begin
                if (collide)
                    nextState = OVER;
                else
                    nextState = pause ? RUNNING_WAIT : RUNNING;   // Jump alone does not pause.
            end
            RUNNING_WAIT: nextState = pause ? RUNNING_WAIT : PAUSE;
            PAUSE:        nextState = startBtn ? PAUSE_WAIT : PAUSE;
            PAUSE_WAIT:   nextState = startBtn ? PAUSE_WAIT : RUNNING;
            OVER:         nextState = startBtn ? OVER_WAIT1 : OVER;
            OVER_WAIT1:   nextState = startBtn ? OVER_WAIT1 : OVER_WAIT2;
            OVER_WAIT2:   nextState = MENU;
            default:      nextState = MENU;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            state <= MENU;
        else
            state <= nextState;
    end

    // Wait states still show the phase they came from.
    always_comb begin
        case (state)
            MENU, MENU_WAIT:                gamePhase = PH_MENU;
            RUNNING, RUNNING_WAIT:          gamePhase = PH_RUNNING;
            PAUSE, PAUSE_WAIT:              gamePhase = PH_PAUSED;
            OVER, OVER_WAIT1, OVER_WAIT2:   gamePhase = PH_OVER;
            default:                        gamePhase = PH_MENU;
        endcase
    end

    // Only nine of sixteen codes are states.
    stateLegal: assert property (
        @(posedge clk) disable iff (!resetn)
        state inside {MENU, MENU_WAIT, RUNNING, RUNNING_WAIT, PAUSE, PAUSE_WAIT,
                      OVER, OVER_WAIT1, OVER_WAIT2}
    ) else $error("gameControl: illegal state %b", state);

endmodule

/* obstacleWorld.sv */
`timescale 1ns/1ps

module obstacleWorld (
    input  logic                   clk,
    input  logic                   resetn,
    input  dinoGamePkg::gamePhaseT gamePhase,
    input  logic                   stepTick,
    output dinoGeomPkg::coordT     obs1X,
    output dinoGeomPkg::coordT     obs2X,
    output logic                   collide
);
    import dinoGeomPkg::*;
    import dinoGamePkg::*;

    logic hit1;
    logic hit2;

    // True when an obstacle starting at column x overlaps the dinosaur columns.
    function automatic logic overlapsDino(coordT x);
        logic [8:0] left;
        logic [8:0] right;
        left  = {1'b0, x};
        right = left + 9'(OBS_W);       // Nine bits, so no wrap.
        return (left < 9'(DINO_RIGHT)) && (right > 9'(DINO_LEFT));
    endfunction

    // Scroll one column left per step.
    always_ff @(posedge clk) begin
        if (!resetn || gamePhase == PH_MENU) begin
            obs1X <= coordT'(OBS1_START);
            obs2X <= coordT'(OBS2_START);
        end else if (stepTick) begin
            obs1X <= obs1X - 1'b1;
            obs2X <= obs2X - 1'b1;
        end
    end

    assign hit1 = overlapsDino(obs1X);
    assign hit2 = overlapsDino(obs2X);

    // Dinosaur is always on the ground, so column overlap is enough.
    always_ff @(posedge clk) begin
        if (!resetn)
            collide <= 1'b0;
        else
            collide <= hit1 || hit2;
    end

endmodule

/* pixelScanner.sv */
`timescale 1ns/1ps

module pixelScanner (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    frameTick,
    input  dinoGeomPkg::coordT      obs1X,
    input  dinoGeomPkg::coordT      obs2X,
    output logic                    pixelValid,
    output dinoGeomPkg::coordT      pixelX,
    output dinoGeomPkg::coordT      pixelY,
    output dinoGamePkg::pixelColorT pixelColor
);
    import dinoGeomPkg::*;
    import dinoGamePkg::*;

    localparam coordT X_LAST = coordT'(SCREEN_W - 1);
    localparam coordT Y_LAST = coordT'(SCREEN_H - 1);

    coordT obs1Frame;
    coordT obs2Frame;
    coordT obs1Use;
    coordT obs2Use;
    coordT nextX;
    coordT nextY;
    logic  lastPixel;

    function automatic logic inObs(coordT x, coordT left);
        logic [8:0] l9;
        l9 = {1'b0, left};
        return ({1'b0, x} >= l9) && ({1'b0, x} < l9 + 9'(OBS_W));
    endfunction

    // Fixed priority, ground on top.
    function automatic pixelColorT colorAt(coordT x, coordT y, coordT o1, coordT o2);
        if (y >= GROUND_TOP)
            return COL_GROUND;
        if (x >= DINO_LEFT && x < DINO_RIGHT && y >= DINO_TOP)
            return COL_DINO;
        if (inObs(x, o1) && y >= GROUND_TOP - OBS1_H)
            return COL_OBS1;
        if (inObs(x, o2) && y >= GROUND_TOP - OBS2_H)
            return COL_OBS2;
        return COL_BG;
    endfunction

    assign lastPixel = pixelValid && pixelX == X_LAST && pixelY == Y_LAST;

    always_comb begin
        if (frameTick) begin
            nextX   = '0;
            nextY   = '0;
            obs1Use = obs1X;    // First pixel sees the live positions.
            obs2Use = obs2X;
        end else begin
            nextX   = (pixelX == X_LAST) ? '0 : pixelX + 1'b1;
            nextY   = (pixelX == X_LAST) ? pixelY + 1'b1 : pixelY;
            obs1Use = obs1Frame;
            obs2Use = obs2Frame;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            pixelValid <= 1'b0;
        else if (frameTick)
            pixelValid <= 1'b1;
        else if (lastPixel)
            pixelValid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (frameTick) begin
            obs1Frame <= obs1X;     // Hold positions for the whole frame.
            obs2Frame <= obs2X;
        end
        if (frameTick || (pixelValid && !lastPixel)) begin
            pixelX     <= nextX;
            pixelY     <= nextY;
            pixelColor <= colorAt(nextX, nextY, obs1Use, obs2Use);
        end
    end

    coordInRange: assert property (
        @(posedge clk) disable iff (!resetn)
        pixelValid |-> pixelX < SCREEN_W && pixelY < SCREEN_H
    ) else $error("pixelScanner: pixel (%0d,%0d) off screen", pixelX, pixelY);

    // Frame period must cover a whole scan.
    noFrameOverlap: assert property (
        @(posedge clk) disable iff (!resetn)
        frameTick |-> !pixelValid || lastPixel
    ) else $error("pixelScanner: frame tick during a scan");

endmodule

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then search the log for the failure line.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module dinoGameTb -o dinoGameTbSim \
    && ./obj_dir/dinoGameTbSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0

/* scoreCounter.sv */
`timescale 1ns/1ps

module scoreCounter (
    input  logic                     clk,
    input  logic                     resetn,
    input  dinoGamePkg::gamePhaseT   gamePhase,
    input  logic                     stepTick,
    output dinoGamePkg::scoreDigitsT score
);
    import dinoGamePkg::*;

    scoreDigitsT nextScore;
    logic        carry;

    // Decimal increment, ones digit first.
    always_comb begin
        carry     = 1'b1;
        nextScore = score;
        for (int i = 0; i < SCORE_DIGITS; i++) begin
            if (carry) begin
                if (score[i] == 4'd9) begin
                    nextScore[i] = 4'd0;    // Carry ripples on.
                end else begin
                    nextScore[i] = score[i] + 4'd1;
                    carry        = 1'b0;
                end
            end
        end
    end

    // Top digit wraps with the carry dropped.
    always_ff @(posedge clk) begin
        if (!resetn || gamePhase == PH_MENU)
            score <= '0;
        else if (stepTick)
            score <= nextScore;
    end

    for (genvar d = 0; d < SCORE_DIGITS; d++) begin : gDigitCheck
        digitBcd: assert property (
            @(posedge clk) disable iff (!resetn)
            score[d] <= 4'd9
        ) else $error("scoreCounter: digit %0d holds %0d", d, score[d]);
    end

endmodule
